// File: vlog.f
hw/bridge_pkg.sv
hw/upload_pkg.sv
hw/frame_parser.sv
hw/cmd_dispatch.sv
hw/pwm_handler.sv
hw/edge_meter.sv
hw/upload_framer.sv
hw/usb_cmd_bridge.sv
tests/tb_clock.sv
tests/tb_usb_cmd_bridge.sv

// File: Bender.yml
package:
  name: usb_cmd_bridge

sources:
  - hw/bridge_pkg.sv
  - hw/upload_pkg.sv
  - hw/frame_parser.sv
  - hw/cmd_dispatch.sv
  - hw/pwm_handler.sv
  - hw/edge_meter.sv
  - hw/upload_framer.sv
  - hw/usb_cmd_bridge.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/tb_usb_cmd_bridge.sv

// File: tests/tb_usb_cmd_bridge.sv
`timescale 1ns/1ps

module tb_usb_cmd_bridge
    import bridge_pkg::*;
    import upload_pkg::*;
();

    localparam int edge_window = 3000;
    localparam int pulse_slots = 750;

    logic       clk;
    logic       rst_n;
    logic [7:0] usb_data;
    logic       usb_valid;
    logic [7:0] edge_inputs;
    logic       led_out;
    logic [7:0] pwm_pins;
    logic [7:0] usb_upload_data;
    logic       usb_upload_valid;

    // Reference model state
    int         errors = 0;
    int         checks = 0;
    logic       led_model = 1'b0;
    logic [7:0] duty_model [8];
    logic [7:0] tx_payload [$];
    logic [7:0] reply_q [$];

    tb_clock clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    usb_cmd_bridge usb_cmd_bridge_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .usb_data         (usb_data),
        .usb_valid        (usb_valid),
        .edge_inputs      (edge_inputs),
        .led_out          (led_out),
        .pwm_pins         (pwm_pins),
        .usb_upload_data  (usb_upload_data),
        .usb_upload_valid (usb_upload_valid)
    );

    // Collect every reply byte the bridge sends to the host
    always @(posedge clk) begin
        if (rst_n && usb_upload_valid) reply_q.push_back(usb_upload_data);
    end

    // ========================================
    // Helpers
    // ========================================
    task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        @(posedge clk);
        usb_data  <= b;
        usb_valid <= 1'b1;
        @(posedge clk);
        usb_valid <= 1'b0;
    endtask

    // Header, opcode, length, payload and checksum followed by a quiet gap
    task automatic send_frame(input logic [7:0] opcode, input logic [15:0] len,
                              input logic corrupt);
        logic [7:0] chk;
        chk = opcode + len[15:8] + len[7:0];
        send_byte(frame_hdr0);
        send_byte(frame_hdr1);
        send_byte(opcode);
        send_byte(len[15:8]);
        send_byte(len[7:0]);
        foreach (tx_payload[i]) begin
            send_byte(tx_payload[i]);
            chk = chk + tx_payload[i];
        end
        if (corrupt) chk = chk ^ 8'($urandom_range(1, 255));
        send_byte(chk);
        repeat (120) @(posedge clk);
    endtask

    task automatic pwm_set(input logic [7:0] ch, input logic [7:0] duty, input logic corrupt);
        tx_payload = {};
        tx_payload.push_back(ch);
        tx_payload.push_back(duty);
        send_frame(cmd_pwm_set, 16'd2, corrupt);
    endtask

    task automatic check_led();
        expect_eq(led_out, led_model, "led_out");
    endtask

    // High time of every pin over one full period
    task automatic measure_pwm();
        int high_cnt [8];
        foreach (high_cnt[i]) high_cnt[i] = 0;
        repeat (pwm_period) begin
            @(posedge clk);
            for (int i = 0; i < 8; i++) begin
                if (pwm_pins[i]) high_cnt[i]++;
            end
        end
        for (int i = 0; i < 8; i++) begin
            expect_eq(high_cnt[i], duty_model[i], $sformatf("pwm_pins[%0d] high cycles", i));
        end
    endtask

    task automatic send_unknown();
        logic [7:0] opcode;
        int         len;
        opcode = 8'h30 + 8'($urandom_range(0, 15));
        len    = $urandom_range(0, 8);
        tx_payload = {};
        repeat (len) tx_payload.push_back(8'($urandom_range(0, 255)));
        send_frame(opcode, 16'(len), 1'b0);
        led_model = ~led_model;
        check_led();
    endtask

    // Payload bytes kept below 0x80 so they never look like a header
    task automatic send_oversize();
        int len;
        len = $urandom_range(max_payload_len + 1, max_payload_len + 16);
        tx_payload = {};
        repeat (len) tx_payload.push_back(8'($urandom_range(0, 127)));
        send_frame(cmd_pwm_set, 16'(len), 1'b0);
        check_led();
    endtask

    task automatic wait_reply(input int nbytes, output bit ok);
        int n;
        n = 0;
        while (reply_q.size() < nbytes && n < 6000) begin
            @(posedge clk);
            n++;
        end
        ok = reply_q.size() >= nbytes;
        if (!ok) begin
            errors++;
            $display("Timeout: reply frame did not arrive within %0d cycles", n);
        end
    endtask

    task automatic run_edge_test();
        int         pulses_left [8];
        int         exp_cnt [8];
        logic [7:0] nxt;
        logic [7:0] sum;
        bit         ok;
        for (int i = 0; i < 8; i++) begin
            pulses_left[i] = $urandom_range(0, 300);
            exp_cnt[i]     = (pulses_left[i] > 255) ? 255 : pulses_left[i];
        end
        tx_payload = {};
        tx_payload.push_back(8'(edge_window >> 8));
        tx_payload.push_back(8'(edge_window));
        send_frame(cmd_edge_measure, 16'd2, 1'b0);
        led_model = ~led_model;
        check_led();
        repeat (80) @(posedge clk);
        // One pulse slot every two cycles with pulses forced once the slots run short
        for (int k = 0; k < pulse_slots; k++) begin
            @(posedge clk);
            for (int i = 0; i < 8; i++) begin
                nxt[i] = (pulses_left[i] > 0) &&
                         ($urandom_range(0, 1) == 1 || pulses_left[i] >= pulse_slots - k);
                if (nxt[i]) pulses_left[i]--;
            end
            edge_inputs <= nxt;
            @(posedge clk);
            edge_inputs <= 8'h00;
        end
        wait_reply(14, ok);
        if (ok) begin
            repeat (40) @(posedge clk);
            expect_eq(reply_q.size(), 14, "reply byte count");
            expect_eq(reply_q.pop_front(), reply_hdr0, "reply header 0");
            expect_eq(reply_q.pop_front(), reply_hdr1, "reply header 1");
            expect_eq(reply_q.pop_front(), src_edge_meter, "reply source");
            expect_eq(reply_q.pop_front(), 8'h00, "reply length high");
            expect_eq(reply_q.pop_front(), 8'd8, "reply length low");
            sum = src_edge_meter + 8'd8;
            for (int i = 0; i < 8; i++) begin
                expect_eq(reply_q.pop_front(), exp_cnt[i], $sformatf("edge count %0d", i));
                sum = sum + 8'(exp_cnt[i]);
            end
            expect_eq(reply_q.pop_front(), sum, "reply checksum");
        end
        reply_q = {};
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        int         n;
        logic [7:0] ch;
        logic [7:0] duty;
        void'($urandom(32'h1a1736e0));
        usb_data    <= 8'h00;
        usb_valid   <= 1'b0;
        edge_inputs <= 8'h00;
        foreach (duty_model[i]) duty_model[i] = 8'h00;

        n = 0;
        while (rst_n !== 1'b1 && n < 50) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            errors++;
            $display("Timeout: reset was never released");
        end
        @(posedge clk);
        expect_eq(led_out, 1'b0, "led_out after reset");
        expect_eq(pwm_pins, 8'h00, "pwm_pins after reset");
        expect_eq(usb_upload_valid, 1'b0, "usb_upload_valid after reset");

        // Good PWM duty updates
        repeat (4) begin
            ch   = 8'($urandom_range(0, 7));
            duty = 8'($urandom_range(0, 255));
            pwm_set(ch, duty, 1'b0);
            duty_model[ch[2:0]] = duty;
            led_model = ~led_model;
            check_led();
            repeat (600) @(posedge clk);
            measure_pwm();
        end

        // Corrupted checksum leaves duties and LED alone
        repeat (2) begin
            ch   = 8'($urandom_range(0, 7));
            duty = 8'($urandom_range(0, 255));
            pwm_set(ch, duty, 1'b1);
            check_led();
            repeat (600) @(posedge clk);
            measure_pwm();
        end

        repeat (2) run_edge_test();

        // Oversize frame is dropped and the next frame still parsed
        repeat (2) begin
            send_oversize();
            send_unknown();
        end

        repeat (3) send_unknown();
        measure_pwm();
        expect_eq(reply_q.size(), 0, "stray reply bytes");

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held low for the first two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: hw/usb_cmd_bridge.sv
`timescale 1ns/1ps

module usb_cmd_bridge
    import bridge_pkg::*;
    import upload_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] usb_data,
    input  logic       usb_valid,
    input  logic [7:0] edge_inputs,
    output logic       led_out,
    output logic [7:0] pwm_pins,
    output logic [7:0] usb_upload_data,
    output logic       usb_upload_valid
);

    // ========================================
    // Parser to dispatcher
    // ========================================
    logic [payload_addr_w-1:0] payload_addr;
    logic [7:0]                payload_data;
    logic                      parse_done;
    logic                      dispatch_busy;
    cmd_opcode_e               frame_opcode;
    logic [15:0]               frame_length;

    // Command bus and handler side
    cmd_bus_t     cmd_bus;
    logic         pwm_ready;
    logic         edge_ready;
    logic         cmd_ready;
    logic         upload_ready;
    upload_req_t  up_req;
    upload_beat_t up_beat;

    // Single gate: every handler must accept before a command goes out
    assign cmd_ready = pwm_ready & edge_ready;

    frame_parser  u_parser   (.*);
    cmd_dispatch  u_dispatch (.*);
    pwm_handler   u_pwm      (.*);
    edge_meter    u_edge     (.*);
    upload_framer u_framer   (.*);

endmodule

// File: hw/upload_framer.sv
`timescale 1ns/1ps

module upload_framer
    import upload_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  upload_req_t  up_req,
    input  upload_beat_t up_beat,
    output logic         upload_ready,
    output logic [7:0]   usb_upload_data,
    output logic         usb_upload_valid
);

    typedef enum logic [3:0] {
        st_idle, st_hdr0, st_hdr1, st_src, st_len_hi, st_len_lo,
        st_data_req, st_data_wait, st_check
    } state_e;

    state_e      state;
    logic [7:0]  src_q;
    logic [15:0] len_q;
    logic [15:0] cnt;
    logic [7:0]  sum;

    // One ready pulse per data byte
    assign upload_ready = state == st_data_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state            <= st_idle;
            src_q            <= 8'h00;
            len_q            <= 16'h0000;
            cnt              <= 16'h0000;
            sum              <= 8'h00;
            usb_upload_data  <= 8'h00;
            usb_upload_valid <= 1'b0;
        end else begin
            usb_upload_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (up_req.req) begin
                        src_q <= up_req.source;
                        len_q <= up_req.length;
                        state <= st_hdr0;
                    end
                end
                st_hdr0: begin
                    usb_upload_data  <= reply_hdr0;
                    usb_upload_valid <= 1'b1;
                    state            <= st_hdr1;
                end
                st_hdr1: begin
                    usb_upload_data  <= reply_hdr1;
                    usb_upload_valid <= 1'b1;
                    state            <= st_src;
                end
                st_src: begin
                    // Checksum starts at the source byte
                    usb_upload_data  <= src_q;
                    usb_upload_valid <= 1'b1;
                    sum              <= src_q;
                    state            <= st_len_hi;
                end
                st_len_hi: begin
                    usb_upload_data  <= len_q[15:8];
                    usb_upload_valid <= 1'b1;
                    sum              <= sum + len_q[15:8];
                    state            <= st_len_lo;
                end
                st_len_lo: begin
                    usb_upload_data  <= len_q[7:0];
                    usb_upload_valid <= 1'b1;
                    sum              <= sum + len_q[7:0];
                    cnt              <= 16'h0000;
                    state            <= (len_q == 16'h0000) ? st_check : st_data_req;
                end
                st_data_req: state <= st_data_wait;
                st_data_wait: begin
                    if (up_beat.valid) begin
                        usb_upload_data  <= up_beat.data;
                        usb_upload_valid <= 1'b1;
                        sum              <= sum + up_beat.data;
                        cnt              <= cnt + 16'd1;
                        state            <= (cnt == len_q - 16'd1) ? st_check : st_data_req;
                    end
                end
                st_check: begin
                    usb_upload_data  <= sum;
                    usb_upload_valid <= 1'b1;
                    state            <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// File: hw/edge_meter.sv
`timescale 1ns/1ps

module edge_meter
    import bridge_pkg::*;
    import upload_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  cmd_bus_t     cmd_bus,
    input  logic [7:0]   edge_inputs,
    input  logic         upload_ready,
    output logic         edge_ready,
    output upload_req_t  up_req,
    output upload_beat_t up_beat
);

    typedef enum logic [1:0] {st_idle, st_arm, st_count, st_upload} state_e;

    state_e                   state;
    logic [edge_channels-1:0] sync1;
    logic [edge_channels-1:0] sync2;
    logic [edge_channels-1:0] prev;
    logic [edge_channels-1:0] rise;
    logic [15:0]              window;
    logic [15:0]              win_left;
    logic [2:0]               ch_idx;
    logic                     beat_valid;
    logic [7:0]               beat_data;
    logic [7:0]               counts [edge_channels];

    assign rise          = sync2 & ~prev;
    assign edge_ready    = state == st_idle;
    assign up_req.req    = state == st_upload;
    assign up_req.source = src_edge_meter;
    assign up_req.length = 16'(edge_channels);
    assign up_beat.valid = beat_valid;
    assign up_beat.data  = beat_data;

    // Window bytes, edge counters and the outgoing byte
    always_ff @(posedge clk) begin
        if (state == st_arm && cmd_bus.data_valid) begin
            if (cmd_bus.index == 16'd0) window[15:8] <= cmd_bus.data;
            if (cmd_bus.index == 16'd1) window[7:0]  <= cmd_bus.data;
        end
        if (state == st_arm && cmd_bus.done) begin
            for (int i = 0; i < edge_channels; i++) counts[i] <= 8'h00;
        end else if (state == st_count && win_left != 16'h0000) begin
            for (int i = 0; i < edge_channels; i++) begin
                if (rise[i] && counts[i] != 8'hFF) counts[i] <= counts[i] + 8'd1;
            end
        end
        if (state == st_upload && upload_ready) beat_data <= counts[ch_idx];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            sync1      <= '0;
            sync2      <= '0;
            prev       <= '0;
            win_left   <= 16'h0000;
            ch_idx     <= 3'd0;
            beat_valid <= 1'b0;
        end else begin
            sync1      <= edge_inputs;
            sync2      <= sync1;
            prev       <= sync2;
            beat_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (cmd_bus.start && cmd_bus.opcode == cmd_edge_measure) state <= st_arm;
                end
                st_arm: begin
                    if (cmd_bus.done) begin
                        win_left <= window;
                        state    <= st_count;
                    end
                end
                st_count: begin
                    if (win_left == 16'h0000) begin
                        ch_idx <= 3'd0;
                        state  <= st_upload;
                    end else begin
                        win_left <= win_left - 16'd1;
                    end
                end
                st_upload: begin
                    // Channel 0 goes first
                    if (upload_ready) begin
                        beat_valid <= 1'b1;
                        ch_idx     <= ch_idx + 3'd1;
                        if (ch_idx == 3'(edge_channels - 1)) state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Each ready pulse is answered by exactly one beat in the next cycle
    a_beat_after_ready: assert property (@(posedge clk) disable iff (!rst_n)
        up_beat.valid == $past(upload_ready));

endmodule

// File: hw/pwm_handler.sv
`timescale 1ns/1ps

module pwm_handler
    import bridge_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  cmd_bus_t   cmd_bus,
    output logic       pwm_ready,
    output logic [7:0] pwm_pins
);

    localparam int cnt_w = $clog2(pwm_period);

    logic [cnt_w-1:0] period_cnt;
    logic [7:0]       ch_q;
    logic [7:0]       duty_q;
    logic [7:0]       duty_next [8];
    logic [7:0]       duty_act  [8];
    logic             is_pwm;

    // Duty updates never stall the bus
    assign pwm_ready = 1'b1;
    assign is_pwm    = cmd_bus.opcode == cmd_pwm_set;

    // Channel at beat 0, duty at beat 1
    always_ff @(posedge clk) begin
        if (is_pwm && cmd_bus.data_valid) begin
            if (cmd_bus.index == 16'd0) ch_q <= cmd_bus.data;
            if (cmd_bus.index == 16'd1) duty_q <= cmd_bus.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            period_cnt <= '0;
            pwm_pins   <= 8'h00;
            for (int i = 0; i < 8; i++) begin
                duty_next[i] <= 8'h00;
                duty_act[i]  <= 8'h00;
            end
        end else begin
            period_cnt <= period_cnt + 1'b1;
            if (is_pwm && cmd_bus.done && cmd_bus.length >= 16'd2 && ch_q < 8'd8) begin
                duty_next[ch_q[2:0]] <= duty_q;
            end
            for (int i = 0; i < 8; i++) begin
                // New duties take effect only at the period wrap
                if (period_cnt == cnt_w'(pwm_period - 1)) duty_act[i] <= duty_next[i];
                pwm_pins[i] <= period_cnt < duty_act[i];
            end
        end
    end

endmodule

// File: hw/cmd_dispatch.sv
`timescale 1ns/1ps

module cmd_dispatch
    import bridge_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      parse_done,
    input  cmd_opcode_e               frame_opcode,
    input  logic [15:0]               frame_length,
    input  logic [7:0]                payload_data,
    input  logic                      cmd_ready,
    output logic [payload_addr_w-1:0] payload_addr,
    output logic                      dispatch_busy,
    output cmd_bus_t                  cmd_bus
);

    typedef enum logic [1:0] {st_idle, st_wait, st_stream, st_done} state_e;

    state_e      state;
    cmd_opcode_e op_q;
    logic [15:0] len_q;
    logic [15:0] issued;
    logic [15:0] beat_idx;
    logic        start_q;
    logic        beat_q;
    logic        done_q;

    assign payload_addr  = issued[payload_addr_w-1:0];
    assign dispatch_busy = (state != st_idle) || done_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            op_q     <= cmd_none;
            len_q    <= 16'h0000;
            issued   <= 16'h0000;
            beat_idx <= 16'h0000;
            start_q  <= 1'b0;
            beat_q   <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            start_q <= 1'b0;
            beat_q  <= 1'b0;
            done_q  <= 1'b0;
            case (state)
                st_idle: begin
                    if (parse_done) begin
                        op_q  <= frame_opcode;
                        len_q <= frame_length;
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    // Hold the command until every handler is ready
                    if (cmd_ready) begin
                        start_q <= 1'b1;
                        issued  <= 16'h0000;
                        state   <= (len_q == 16'h0000) ? st_done : st_stream;
                    end
                end
                st_stream: begin
                    // Address issued now returns as a beat next cycle
                    beat_q   <= 1'b1;
                    beat_idx <= issued;
                    issued   <= issued + 16'd1;
                    if (issued == len_q - 16'd1) state <= st_done;
                end
                st_done: begin
                    done_q <= 1'b1;
                    state  <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_comb begin
        cmd_bus.opcode     = op_q;
        cmd_bus.length     = len_q;
        cmd_bus.data       = payload_data;
        cmd_bus.index      = beat_idx;
        cmd_bus.start      = start_q;
        cmd_bus.data_valid = beat_q;
        cmd_bus.done       = done_q;
    end

    a_start_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(cmd_bus.start && cmd_bus.data_valid));

endmodule

// File: hw/frame_parser.sv
`timescale 1ns/1ps

module frame_parser
    import bridge_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [7:0]                usb_data,
    input  logic                      usb_valid,
    input  logic [payload_addr_w-1:0] payload_addr,
    input  logic                      dispatch_busy,
    output logic [7:0]                payload_data,
    output logic                      parse_done,
    output cmd_opcode_e               frame_opcode,
    output logic [15:0]               frame_length,
    output logic                      led_out
);

    typedef enum logic [2:0] {
        st_hdr0, st_hdr1, st_opcode, st_len_hi, st_len_lo, st_payload, st_check
    } state_e;

    state_e                  state;
    logic                    valid_d;
    logic                    byte_stb;
    logic [7:0]              sum;
    logic [payload_addr_w:0] wr_idx;
    logic [7:0]              buffer [max_payload_len];

    // One byte per rising edge of usb_valid, ignored while a command plays out
    assign byte_stb = usb_valid && !valid_d && !dispatch_busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= st_hdr0;
            valid_d      <= 1'b0;
            sum          <= 8'h00;
            wr_idx       <= '0;
            parse_done   <= 1'b0;
            frame_opcode <= cmd_none;
            frame_length <= 16'h0000;
            led_out      <= 1'b0;
        end else begin
            valid_d    <= usb_valid;
            parse_done <= 1'b0;
            if (byte_stb) begin
                case (state)
                    st_hdr0: begin
                        if (usb_data == frame_hdr0) state <= st_hdr1;
                    end
                    st_hdr1: begin
                        // A repeated 0xAA may still open a frame
                        if (usb_data == frame_hdr1) state <= st_opcode;
                        else if (usb_data != frame_hdr0) state <= st_hdr0;
                    end
                    st_opcode: begin
                        frame_opcode <= cmd_opcode_e'(usb_data);
                        sum          <= usb_data;
                        state        <= st_len_hi;
                    end
                    st_len_hi: begin
                        frame_length[15:8] <= usb_data;
                        sum                <= sum + usb_data;
                        state              <= st_len_lo;
                    end
                    st_len_lo: begin
                        frame_length[7:0] <= usb_data;
                        sum               <= sum + usb_data;
                        wr_idx            <= '0;
                        if ({frame_length[15:8], usb_data} > 16'(max_payload_len)) begin
                            state <= st_hdr0;
                        end else if ({frame_length[15:8], usb_data} == 16'h0000) begin
                            state <= st_check;
                        end else begin
                            state <= st_payload;
                        end
                    end
                    st_payload: begin
                        sum    <= sum + usb_data;
                        wr_idx <= wr_idx + 1'b1;
                        if (16'(wr_idx) + 16'd1 == frame_length) state <= st_check;
                    end
                    st_check: begin
                        state <= st_hdr0;
                        if (usb_data == sum) begin
                            parse_done <= 1'b1;
                            led_out    <= ~led_out;
                        end
                    end
                    default: state <= st_hdr0;
                endcase
            end
        end
    end

    // Payload buffer, read data lags the address by one cycle
    always_ff @(posedge clk) begin
        if (byte_stb && state == st_payload) begin
            buffer[wr_idx[payload_addr_w-1:0]] <= usb_data;
        end
        payload_data <= buffer[payload_addr];
    end

    // The length check must have stopped any frame that would overrun the buffer
    a_wr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        byte_stb && state == st_payload |-> wr_idx < max_payload_len);

endmodule

// File: hw/upload_pkg.sv
package upload_pkg;

    // Reply frame header
    localparam logic [7:0] reply_hdr0 = 8'hAA;
    localparam logic [7:0] reply_hdr1 = 8'h44;

    // Source ids
    localparam logic [7:0] src_edge_meter = 8'h0A;

    localparam int edge_channels = 8;

    typedef struct packed {
        logic        req;
        logic [7:0]  source;
        logic [15:0] length;
    } upload_req_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } upload_beat_t;

endpackage

// File: hw/bridge_pkg.sv
package bridge_pkg;

    // ========================================
    // Host frame format
    // ========================================
    localparam logic [7:0] frame_hdr0 = 8'hAA;
    localparam logic [7:0] frame_hdr1 = 8'h55;

    // Payload buffer depth and address width
    localparam int max_payload_len = 64;
    localparam int payload_addr_w  = 6;

    // PWM period in clocks
    localparam int pwm_period = 256;

    // Opcodes understood by the handlers
    typedef enum logic [7:0] {
        cmd_none         = 8'h00,
        cmd_pwm_set      = 8'h10,
        cmd_edge_measure = 8'h20
    } cmd_opcode_e;

    // ========================================
    // Command bus
    // ========================================
    typedef struct packed {
        cmd_opcode_e opcode;
        logic [15:0] length;
        logic [7:0]  data;
        logic [15:0] index;
        logic        start;
        logic        data_valid;
        logic        done;
    } cmd_bus_t;

endpackage
